/* logic/md_defs.svh */
// Multiply/divide unit widths, buffer depths and pipeline depths.
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Operand and tag widths.
`define MD_WIDTH        32
`define MD_TAG_WIDTH    4

// Result buffer slots per pipeline and initial downstream credits.
`define MD_BUF_DEPTH    4
`define MD_OUT_CREDITS  2

// Pipeline depths.
`define MD_DIV_STAGES   4
`define MD_MUL_STAGES   2

`endif

/* logic/md_pkg.sv */
// Multiply/divide unit types shared by the issue stage, pipelines and arbiter.
`default_nettype none

`include "md_defs.svh"

package md_pkg;

    typedef logic [`MD_WIDTH-1:0]     word_t;
    typedef logic [2*`MD_WIDTH-1:0]   dword_t;
    typedef logic [`MD_TAG_WIDTH-1:0] tag_t;

    typedef enum logic {
        MD_MULTU = 1'b0,
        MD_DIVU  = 1'b1
    } md_op_t;

    typedef struct packed {
        md_op_t op;
        tag_t   tag;
        word_t  a;
        word_t  b;
    } md_req_t;

    // Division puts the quotient in lo and the remainder in hi.
    typedef struct packed {
        tag_t  tag;
        word_t hi;
        word_t lo;
    } md_result_t;

    // Dividend shifts out at the top while quotient bits fill in below.
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t dividend;
        word_t divisor;
        word_t rem;
    } md_stage_t;

endpackage

`default_nettype wire

/* logic/md_issue.sv */
// Issue stage that steers requests to the divider or multiplier under credit control.
`default_nettype none

`include "md_defs.svh"

module md_issue import md_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid,
    input  md_req_t req,
    output logic    req_ready,
    output logic    div_in_valid,
    output logic    mul_in_valid,
    output md_req_t div_in,
    output md_req_t mul_in,
    input  logic    div_credit,
    input  logic    mul_credit
);
    localparam int CW = $clog2(`MD_BUF_DEPTH + 1);
    typedef logic [CW-1:0] credit_t;

    credit_t div_cnt;
    credit_t mul_cnt;
    logic    is_div;
    logic    accept;

    function automatic credit_t credit_next(input credit_t cnt, input logic inc,
                                            input logic dec);
        case ({inc, dec})
            2'b10:   return cnt + 1'b1;
            2'b01:   return cnt - 1'b1;
            default: return cnt;
        endcase
    endfunction

    assign is_div    = (req.op == MD_DIVU);
    assign req_ready = is_div ? (div_cnt != '0) : (mul_cnt != '0);
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt      <= credit_t'(`MD_BUF_DEPTH);
            mul_cnt      <= credit_t'(`MD_BUF_DEPTH);
            div_in_valid <= 1'b0;
            mul_in_valid <= 1'b0;
        end else begin
            div_cnt      <= credit_next(div_cnt, div_credit, accept && is_div);
            mul_cnt      <= credit_next(mul_cnt, mul_credit, accept && !is_div);
            div_in_valid <= accept && is_div;
            mul_in_valid <= accept && !is_div;
        end
    end

    // Request payload toward the pipelines.
    always_ff @(posedge clk) begin
        if (accept && is_div) begin
            div_in <= req;
        end
        if (accept && !is_div) begin
            mul_in <= req;
        end
    end

endmodule

`default_nettype wire

/* logic/divider.sv */
// Pipelined unsigned restoring divider with a fixed number of steps per stage.
`default_nettype none

`include "md_defs.svh"

module divider import md_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  md_req_t    in,
    output logic       out_valid,
    output md_result_t out
);
    localparam int NSTAGE = `MD_DIV_STAGES;
    localparam int STEPS  = `MD_WIDTH / `MD_DIV_STAGES;

    md_stage_t stage_in;
    md_stage_t stage_d [NSTAGE];
    md_stage_t stage_q [NSTAGE];

    // One stage worth of restoring steps.
    function automatic md_stage_t div_steps(input md_stage_t st);
        md_stage_t          nx;
        logic [`MD_WIDTH:0] shifted;
        logic               fits;
        nx = st;
        for (int i = 0; i < STEPS; i++) begin
            shifted = {nx.rem, nx.dividend[`MD_WIDTH-1]};
            fits    = (shifted >= {1'b0, nx.divisor});
            if (fits) begin
                shifted = shifted - {1'b0, nx.divisor};
            end
            // Remainder stays below the divisor, so the top bit is zero here.
            nx.rem      = shifted[`MD_WIDTH-1:0];
            nx.dividend = {nx.dividend[`MD_WIDTH-2:0], fits};
        end
        return nx;
    endfunction

    always_comb begin
        stage_in.valid    = in_valid;
        stage_in.tag      = in.tag;
        stage_in.dividend = in.a;
        stage_in.divisor  = in.b;
        stage_in.rem      = '0;
    end

    always_comb begin
        stage_d[0] = div_steps(stage_in);
        for (int s = 1; s < NSTAGE; s++) begin
            stage_d[s] = div_steps(stage_q[s-1]);
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < NSTAGE; s++) begin
            stage_q[s] <= stage_d[s];
            if (reset) begin
                stage_q[s].valid <= 1'b0;
            end
        end
    end

    // After the last stage the dividend field holds the quotient.
    assign out_valid = stage_q[NSTAGE-1].valid;
    assign out.tag   = stage_q[NSTAGE-1].tag;
    assign out.hi    = stage_q[NSTAGE-1].rem;
    assign out.lo    = stage_q[NSTAGE-1].dividend;

endmodule

`default_nettype wire

/* logic/multiplier.sv */
// Two-stage unsigned multiplier built from four half-width partial products.
`default_nettype none

`include "md_defs.svh"

module multiplier import md_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  md_req_t    in,
    output logic       out_valid,
    output md_result_t out
);
    localparam int H = `MD_WIDTH / 2;

    logic [`MD_MUL_STAGES-1:0] valid_pipe;
    tag_t   tag_q;
    word_t  pp_ll;
    word_t  pp_lh;
    word_t  pp_hl;
    word_t  pp_hh;
    dword_t product;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`MD_MUL_STAGES-2:0], in_valid};
        end
    end

    // Stage one.
    always_ff @(posedge clk) begin
        tag_q <= in.tag;
        pp_ll <= in.a[H-1:0] * in.b[H-1:0];
        pp_lh <= in.a[H-1:0] * in.b[`MD_WIDTH-1:H];
        pp_hl <= in.a[`MD_WIDTH-1:H] * in.b[H-1:0];
        pp_hh <= in.a[`MD_WIDTH-1:H] * in.b[`MD_WIDTH-1:H];
    end

    // Cross terms land in the middle of the product.
    assign product = {pp_hh, pp_ll} + (dword_t'(pp_lh) << H) + (dword_t'(pp_hl) << H);

    // Stage two.
    always_ff @(posedge clk) begin
        out.tag <= tag_q;
        out.hi  <= product[2*`MD_WIDTH-1:`MD_WIDTH];
        out.lo  <= product[`MD_WIDTH-1:0];
    end

    assign out_valid = valid_pipe[`MD_MUL_STAGES-1];

endmodule

`default_nettype wire

/* logic/hilo_arbiter.sv */
// Result buffers and round-robin arbiter for the shared HI/LO result port.
`default_nettype none

`include "md_defs.svh"

module hilo_arbiter import md_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       div_valid,
    input  logic       mul_valid,
    input  md_result_t div_result,
    input  md_result_t mul_result,
    output logic       div_credit,
    output logic       mul_credit,
    output logic       result_valid,
    output md_result_t result,
    input  logic       result_credit
);
    localparam int DEPTH = `MD_BUF_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int OW    = $clog2(`MD_OUT_CREDITS + 1);

    typedef logic [PW-1:0] ptr_t;
    typedef logic [CW-1:0] count_t;
    typedef logic [OW-1:0] out_cnt_t;

    // Index 0 is the divider buffer, index 1 the multiplier buffer.
    md_result_t buf_mem [2][DEPTH];
    md_result_t push_data [2];
    ptr_t       wr_ptr [2];
    ptr_t       rd_ptr [2];
    count_t     count [2];
    logic [1:0] push;
    logic [1:0] nonempty;
    logic [1:0] pop_vec;
    logic       grant;
    logic       last;
    logic       pop;
    out_cnt_t   out_cnt;

    assign push         = {mul_valid, div_valid};
    assign push_data[0] = div_result;
    assign push_data[1] = mul_result;
    assign nonempty     = {count[1] != '0, count[0] != '0};

    // The buffer not served last wins a tie.
    always_comb begin
        case (nonempty)
            2'b01:   grant = 1'b0;
            2'b10:   grant = 1'b1;
            default: grant = ~last;
        endcase
    end

    assign pop     = (out_cnt != '0) && (nonempty != 2'b00);
    assign pop_vec = pop ? (grant ? 2'b10 : 2'b01) : 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < 2; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            last         <= 1'b1;
            out_cnt      <= out_cnt_t'(`MD_OUT_CREDITS);
            result_valid <= 1'b0;
            div_credit   <= 1'b0;
            mul_credit   <= 1'b0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (push[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (pop_vec[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                count[p] <= count[p] + count_t'(push[p]) - count_t'(pop_vec[p]);
            end
            if (pop) begin
                last <= grant;
            end
            out_cnt      <= out_cnt + out_cnt_t'(result_credit) - out_cnt_t'(pop);
            result_valid <= pop;
            div_credit   <= pop_vec[0];
            mul_credit   <= pop_vec[1];
        end
    end

    // Buffer storage and result payload.
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (push[p]) begin
                buf_mem[p][wr_ptr[p]] <= push_data[p];
            end
        end
        if (pop) begin
            result <= buf_mem[grant][rd_ptr[grant]];
        end
    end

endmodule

`default_nettype wire

/* logic/md_unit.sv */
// Multiply/divide unit top level joining issue, both pipelines and the result arbiter.
`default_nettype none

module md_unit import md_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  md_req_t    req,
    output logic       req_ready,
    output logic       result_valid,
    output md_result_t result,
    input  logic       result_credit
);
    logic       div_in_valid;
    logic       mul_in_valid;
    md_req_t    div_in;
    md_req_t    mul_in;
    logic       div_credit;
    logic       mul_credit;
    logic       div_out_valid;
    logic       mul_out_valid;
    md_result_t div_out;
    md_result_t mul_out;

    md_issue u_issue (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .div_in_valid (div_in_valid),
        .mul_in_valid (mul_in_valid),
        .div_in       (div_in),
        .mul_in       (mul_in),
        .div_credit   (div_credit),
        .mul_credit   (mul_credit)
    );

    divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (div_in_valid),
        .in        (div_in),
        .out_valid (div_out_valid),
        .out       (div_out)
    );

    multiplier u_multiplier (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_in_valid),
        .in        (mul_in),
        .out_valid (mul_out_valid),
        .out       (mul_out)
    );

    hilo_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .div_valid     (div_out_valid),
        .mul_valid     (mul_out_valid),
        .div_result    (div_out),
        .mul_result    (mul_out),
        .div_credit    (div_credit),
        .mul_credit    (mul_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

endmodule

`default_nettype wire

/* testbench/tb_md_unit.sv */
// Testbench for the multiply/divide unit with a reference model and a credit-based consumer.
`default_nettype none

`include "md_defs.svh"

module tb_md_unit
    import md_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        md_op_t     op;
        word_t      a;
        word_t      b;
        logic [3:0] hold;
    } row_t;

    typedef struct packed {
        tag_t       tag;
        word_t      hi;
        word_t      lo;
        logic [3:0] hold;
    } expect_t;

    localparam int NROWS     = 28;
    localparam int MUL_FIRST = 0;
    localparam int DIV_FIRST = 3;
    localparam int MIX_FIRST = 8;
    localparam int BP_FIRST  = 14;
    localparam int ALT_FIRST = 20;
    localparam int LIMIT     = 40 * NROWS + 200;

    // Columns are op, a, b and the consumer hold count.
    localparam row_t ROWS [NROWS] = '{
        '{MD_MULTU, 32'h0000_0003, 32'h0000_0005, 4'd0},
        '{MD_MULTU, 32'hffff_ffff, 32'hffff_ffff, 4'd1},
        '{MD_MULTU, 32'h1234_5678, 32'h9abc_def0, 4'd0},
        '{MD_DIVU,  32'h0000_0064, 32'h0000_0007, 4'd0},
        '{MD_DIVU,  32'h0000_0005, 32'h0000_0009, 4'd1},
        '{MD_DIVU,  32'hffff_ffff, 32'hffff_ffff, 4'd0},
        '{MD_DIVU,  32'hffff_ffff, 32'h0000_0001, 4'd2},
        '{MD_DIVU,  32'h1234_5678, 32'h0000_0000, 4'd0},
        '{MD_DIVU,  32'h8000_0000, 32'h0000_0003, 4'd2},
        '{MD_MULTU, 32'h0001_0000, 32'h0001_0000, 4'd0},
        '{MD_DIVU,  32'hdead_beef, 32'h0000_0010, 4'd1},
        '{MD_MULTU, 32'hffff_ffff, 32'h0000_0002, 4'd3},
        '{MD_MULTU, 32'h0000_0007, 32'h0000_0000, 4'd0},
        '{MD_DIVU,  32'h0000_0000, 32'h0000_0005, 4'd1},
        '{MD_MULTU, 32'h0000_1111, 32'h0000_2222, 4'd0},
        '{MD_MULTU, 32'h8000_0001, 32'h0000_0003, 4'd0},
        '{MD_MULTU, 32'h0bad_cafe, 32'h1357_9bdf, 4'd0},
        '{MD_MULTU, 32'h0000_ffff, 32'hffff_0000, 4'd0},
        '{MD_MULTU, 32'h7fff_ffff, 32'h7fff_ffff, 4'd0},
        '{MD_MULTU, 32'h0000_0001, 32'hcafe_f00d, 4'd0},
        '{MD_DIVU,  32'h0001_0000, 32'h0000_0100, 4'd0},
        '{MD_MULTU, 32'h0000_0010, 32'h0000_0020, 4'd1},
        '{MD_DIVU,  32'h0000_03e8, 32'h0000_0021, 4'd0},
        '{MD_MULTU, 32'haaaa_aaaa, 32'h5555_5555, 4'd0},
        '{MD_DIVU,  32'hfedc_ba98, 32'h0001_2345, 4'd1},
        '{MD_MULTU, 32'h0000_0100, 32'h0100_0000, 4'd0},
        '{MD_DIVU,  32'h0000_0001, 32'h0000_0002, 4'd0},
        '{MD_MULTU, 32'hffff_fffe, 32'h0000_0003, 4'd2}
    };

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       req_valid = 1'b0;
    md_req_t    req = '0;
    logic       req_ready;
    logic       result_valid;
    md_result_t result;
    logic       result_credit = 1'b0;

    int         cycle = 0;
    int         errors = 0;
    int         taken = 0;
    int         seed = 54583;
    logic       withhold = 1'b0;
    logic [15:0] seen = '0;
    expect_t    div_q [$];
    expect_t    mul_q [$];
    int         credit_due [$];
    logic       src_log [$];

    md_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= LIMIT) begin
            $display("Timeout after %0d cycles with operations still outstanding", cycle);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // Consumer side, sampled at the falling edge where the port is stable.
    always @(negedge clk) begin
        expect_t e;
        logic    from_div;
        logic    matched;
        int      extra;
        if (!reset && result_valid) begin
            taken++;
            matched = 1'b1;
            from_div = 1'b0;
            if (seen[result.tag]) begin
                errors++;
                $display("Tag %h was returned more than once", result.tag);
            end
            seen[result.tag] = 1'b1;
            if (div_q.size() > 0 && div_q[0].tag == result.tag) begin
                e = div_q.pop_front();
                from_div = 1'b1;
            end else if (mul_q.size() > 0 && mul_q[0].tag == result.tag) begin
                e = mul_q.pop_front();
            end else begin
                matched = 1'b0;
                errors++;
                $display("Tag %h does not match the next expected result of either pipeline",
                         result.tag);
            end
            extra = (($random(seed) & 7) == 0) ? 3 : 0;
            if (matched) begin
                compare("result.hi", result.hi, e.hi);
                compare("result.lo", result.lo, e.lo);
                src_log.push_back(from_div);
                credit_due.push_back(cycle + e.hold + extra);
            end else begin
                credit_due.push_back(cycle);
            end
        end
    end

    // One credit pulse per cycle at most.
    always @(posedge clk) begin
        #2;
        if (!withhold && credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            result_credit = 1'b1;
        end else begin
            result_credit = 1'b0;
        end
    end

    task automatic issue_row(input int idx);
        logic    accepted;
        expect_t e;
        dword_t  prod;
        accepted = 1'b0;
        req_valid = 1'b1;
        req.op = ROWS[idx].op;
        req.tag = tag_t'(idx);
        req.a = ROWS[idx].a;
        req.b = ROWS[idx].b;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #2;
        end
        req_valid = 1'b0;
        e.tag = tag_t'(idx);
        e.hold = ROWS[idx].hold;
        if (ROWS[idx].op == MD_MULTU) begin
            prod = dword_t'(ROWS[idx].a) * dword_t'(ROWS[idx].b);
            e.hi = prod[63:32];
            e.lo = prod[31:0];
            mul_q.push_back(e);
        end else begin
            // Divide by zero leaves an all-ones quotient and the dividend as remainder.
            if (ROWS[idx].b == '0) begin
                e.lo = '1;
                e.hi = ROWS[idx].a;
            end else begin
                e.lo = ROWS[idx].a / ROWS[idx].b;
                e.hi = ROWS[idx].a % ROWS[idx].b;
            end
            div_q.push_back(e);
        end
    endtask

    task automatic run_rows(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            issue_row(first + i);
        end
    endtask

    task automatic drain();
        while (div_q.size() != 0 || mul_q.size() != 0 || credit_due.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic report(input string name, input int first_err);
        $display("%s: %0d errors", name, errors - first_err);
    endtask

    initial begin
        int first_err;
        int taken_before;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        first_err = errors;
        req.op = MD_MULTU;
        #1;
        compare("req_ready", req_ready, 1);
        req.op = MD_DIVU;
        #1;
        compare("req_ready", req_ready, 1);
        compare("result_valid", result_valid, 0);
        report("reset state", first_err);
        @(posedge clk);
        #2;

        first_err = errors;
        seen = '0;
        run_rows(MUL_FIRST, DIV_FIRST - MUL_FIRST);
        drain();
        report("multiplications", first_err);

        first_err = errors;
        seen = '0;
        run_rows(DIV_FIRST, MIX_FIRST - DIV_FIRST);
        drain();
        report("divisions", first_err);

        first_err = errors;
        seen = '0;
        run_rows(MIX_FIRST, BP_FIRST - MIX_FIRST);
        drain();
        report("interleaved operations", first_err);

        // Multiplier buffer fills while the consumer keeps its credits.
        first_err = errors;
        seen = '0;
        withhold = 1'b1;
        taken_before = taken;
        run_rows(BP_FIRST, ALT_FIRST - BP_FIRST);
        repeat (12) @(posedge clk);
        #2;
        compare("results taken", taken - taken_before, `MD_OUT_CREDITS);
        req.op = MD_MULTU;
        #1;
        compare("req_ready", req_ready, 0);
        req.op = MD_DIVU;
        #1;
        compare("req_ready", req_ready, 1);
        withhold = 1'b0;
        drain();
        report("back-pressure", first_err);

        first_err = errors;
        seen = '0;
        src_log.delete();
        withhold = 1'b1;
        taken_before = taken;
        run_rows(ALT_FIRST, NROWS - ALT_FIRST);
        repeat (12) @(posedge clk);
        #2;
        compare("results taken", src_log.size(), `MD_OUT_CREDITS);
        withhold = 1'b0;
        drain();
        compare("results taken", taken - taken_before, NROWS - ALT_FIRST);
        for (int i = `MD_OUT_CREDITS; i < src_log.size(); i++) begin
            if (src_log[i] == src_log[i-1]) begin
                errors++;
                $display("Results %0d and %0d both came from the same pipeline", i - 1, i);
            end
        end
        report("round-robin", first_err);

        $display("Summary: %0d results checked, %0d errors", taken, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* md_unit.f */
+incdir+logic
logic/md_pkg.sv
logic/md_issue.sv
logic/divider.sv
logic/multiplier.sv
logic/hilo_arbiter.sv
logic/md_unit.sv
testbench/tb_md_unit.sv

/* run_sim.sh */
#!/bin/sh
# Builds the multiply/divide unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f md_unit.f --top-module tb_md_unit -o sim_md_unit
sim_out=$(./obj_dir/sim_md_unit)
echo "$sim_out"

if echo "$sim_out" | grep -q "^Finished with no errors$"; then
    exit 0
fi
exit 1
